/* Makefile */
TOP := apuTb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
		--top-module $(TOP) -Mdir obj_dir -f sim.f
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG) || (echo "Simulation failed"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* common/apuPkg.sv */
//--------------------------------------
// APU shared types and tables
//--------------------------------------
package apuPkg;

  typedef logic [4:0]  regAddrT;
  typedef logic [3:0]  sampleT;
  typedef logic [15:0] mixOutT;
  typedef logic [10:0] periodT;
  typedef logic [7:0]  lenCountT;

  // Register map
  localparam regAddrT Pulse1Base    = 5'h00;
  localparam regAddrT Pulse2Base    = 5'h04;
  localparam regAddrT StatusAddr    = 5'h15;
  localparam regAddrT FrameCtrlAddr = 5'h17;

  // Frame sequencer step points, in clk cycles
  localparam logic [15:0] StepQuarter1 = 16'd7457;
  localparam logic [15:0] StepHalf1    = 16'd14913;
  localparam logic [15:0] StepQuarter3 = 16'd22371;
  localparam logic [15:0] StepEnd4     = 16'd29829;
  localparam logic [15:0] StepEnd5     = 16'd37281;

  // Length counter load values, indexed by wrData[7:3]
  localparam lenCountT LengthTable [32] = '{
    8'h0A, 8'hFE, 8'h14, 8'h02, 8'h28, 8'h04, 8'h50, 8'h06,
    8'hA0, 8'h08, 8'h3C, 8'h0A, 8'h0E, 8'h0C, 8'h1A, 8'h0E,
    8'h0C, 8'h10, 8'h18, 8'h12, 8'h30, 8'h14, 8'h60, 8'h16,
    8'hC0, 8'h18, 8'h48, 8'h1A, 8'h10, 8'h1C, 8'h20, 8'h1E
  };

  // Non-linear pulse mix, indexed by pulse1 + pulse2
  localparam mixOutT PulseMixTable [31] = '{
    16'd0,     16'd760,   16'd1503,  16'd2228,  16'd2936,  16'd3627,
    16'd4303,  16'd4963,  16'd5609,  16'd6240,  16'd6858,  16'd7462,
    16'd8053,  16'd8631,  16'd9198,  16'd9752,  16'd10296, 16'd10828,
    16'd11349, 16'd11860, 16'd12361, 16'd12852, 16'd13334, 16'd13807,
    16'd14270, 16'd14725, 16'd15171, 16'd15609, 16'd16039, 16'd16461,
    16'd16876
  };

  // Duty waveforms, bit n is the output at sequence position n
  localparam logic [7:0] DutyPattern [4] = '{
    8'b1000_0000,  // 12.5%
    8'b1100_0000,  // 25%
    8'b1111_0000,  // 50%
    8'b0011_1111   // 25% inverted
  };

  localparam periodT MinValidPeriod = 11'd8;
  localparam sampleT EnvelopeMax    = 4'd15;

endpackage

/* common/pulseRegIf.sv */
//--------------------------------------
// Pulse channel register port
//--------------------------------------
`timescale 1ns/1ps

interface pulseRegIf;
  logic       wrEn;          // One-cycle write strobe
  logic [1:0] regAddr;       // Register within the channel window
  logic [7:0] wrData;
  logic       enabled;       // Channel enable from the status register
  logic       lengthActive;  // Length counter nonzero

  modport bank (
    output wrEn, regAddr, wrData, enabled,
    input  lengthActive
  );

  modport channel (
    input  wrEn, regAddr, wrData, enabled,
    output lengthActive
  );
endinterface

/* pulse/pulseChannel.sv */
//--------------------------------------
// Square wave channel
//--------------------------------------
`timescale 1ns/1ps

module pulseChannel
  import apuPkg::*;
#(
  parameter bit negateCarry = 1'b0  // Add-in for sweep subtraction
)
(
  input  logic        clk,
  input  logic        reset,
  input  logic        quarterFrame,
  input  logic        halfFrame,
  pulseRegIf.channel  regs,
  output sampleT      sample
);

  // Register 0
  logic [1:0] duty;
  logic       lenHalt;       // Also the envelope loop flag
  logic       constVolume;
  sampleT     volume;
  // Register 1
  logic       sweepEnable;
  logic [2:0] sweepPeriod;
  logic       sweepNegate;
  logic [2:0] sweepShift;
  logic       sweepReload;
  // Registers 2 and 3
  periodT     period;

  logic [11:0] timer;
  logic [2:0]  seqPos;
  lenCountT    lengthCount;
  sampleT      envelope;
  sampleT      envDivider;
  logic        envStart;
  logic [2:0]  sweepDivider;

  periodT      shiftedPeriod;
  periodT      sweepDelta;
  logic [11:0] sweepTarget;
  logic        validFreq;
  logic        dutyBit;

  //--------------------------------------
  // Sweep target and muting
  //--------------------------------------
  assign shiftedPeriod = period >> sweepShift;
  assign sweepDelta    = sweepNegate ? (~shiftedPeriod + periodT'(negateCarry)) : shiftedPeriod;
  assign sweepTarget   = {1'b0, period} + {1'b0, sweepDelta};
  assign validFreq     = (period >= MinValidPeriod) && (sweepNegate || !sweepTarget[11]);

  always_ff @(posedge clk) begin
    if (reset) begin
      duty         <= 2'd0;
      lenHalt      <= 1'b0;
      constVolume  <= 1'b0;
      volume       <= 4'd0;
      sweepEnable  <= 1'b0;
      sweepPeriod  <= 3'd0;
      sweepNegate  <= 1'b0;
      sweepShift   <= 3'd0;
      sweepReload  <= 1'b0;
      period       <= 11'd0;
      timer        <= 12'd0;
      seqPos       <= 3'd0;
      lengthCount  <= 8'd0;
      envelope     <= 4'd0;
      envDivider   <= 4'd0;
      envStart     <= 1'b0;
      sweepDivider <= 3'd0;
    end else begin
      // Timer runs at half rate, one duty step per expiry
      if (timer == 12'd0) begin
        timer  <= {period, 1'b0};
        seqPos <= seqPos - 3'd1;
      end else begin
        timer <= timer - 12'd1;
      end

      if (quarterFrame) begin
        if (envStart) begin
          envStart   <= 1'b0;
          envelope   <= EnvelopeMax;
          envDivider <= volume;
        end else if (envDivider == 4'd0) begin
          envDivider <= volume;
          if (envelope != 4'd0)
            envelope <= envelope - 4'd1;
          else if (lenHalt)
            envelope <= EnvelopeMax;  // Looping envelope
        end else begin
          envDivider <= envDivider - 4'd1;
        end
      end

      if (halfFrame) begin
        if (lengthCount != 8'd0 && !lenHalt)
          lengthCount <= lengthCount - 8'd1;
        if (sweepDivider == 3'd0) begin
          sweepDivider <= sweepPeriod;
          if (sweepEnable && sweepShift != 3'd0 && validFreq)
            period <= sweepTarget[10:0];
        end else begin
          sweepDivider <= sweepDivider - 3'd1;
        end
        if (sweepReload)
          sweepDivider <= sweepPeriod;
        sweepReload <= 1'b0;
      end

      // Register writes take priority over the frame clocks
      if (regs.wrEn) begin
        case (regs.regAddr)
          2'd0: begin
            duty        <= regs.wrData[7:6];
            lenHalt     <= regs.wrData[5];
            constVolume <= regs.wrData[4];
            volume      <= regs.wrData[3:0];
          end
          2'd1: begin
            sweepEnable <= regs.wrData[7];
            sweepPeriod <= regs.wrData[6:4];
            sweepNegate <= regs.wrData[3];
            sweepShift  <= regs.wrData[2:0];
            sweepReload <= 1'b1;
          end
          2'd2: begin
            period[7:0] <= regs.wrData;
          end
          default: begin
            period[10:8] <= regs.wrData[2:0];
            lengthCount  <= LengthTable[regs.wrData[7:3]];
            envStart     <= 1'b1;
            seqPos       <= 3'd0;
          end
        endcase
      end

      if (!regs.enabled)
        lengthCount <= 8'd0;
    end
  end

  assign regs.lengthActive = (lengthCount != 8'd0);
  assign dutyBit           = DutyPattern[duty][seqPos];

  always_comb begin
    if (lengthCount == 8'd0 || !validFreq || !dutyBit)
      sample = 4'd0;
    else
      sample = constVolume ? volume : envelope;
  end

endmodule

/* rtl/apbRegBank.sv */
//--------------------------------------
// APB register bank
//--------------------------------------
`timescale 1ns/1ps

module apbRegBank
  import apuPkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  logic          psel,
  input  logic          penable,
  input  logic          pwrite,
  input  regAddrT       paddr,
  input  logic [7:0]    pwdata,
  input  logic          frameEvent,
  output logic [7:0]    prdata,
  output logic          pready,
  output logic          seqMode,
  output logic          restart,
  output logic          irq,
  pulseRegIf.bank       pulse1,
  pulseRegIf.bank       pulse2
);

  logic       wrAccess;
  logic       rdAccess;
  logic       statusWr;
  logic       statusRd;
  logic       frameWr;
  logic [1:0] enableBits;
  logic       irqInhibit;
  logic       frameIrq;
  logic [7:0] statusByte;

  // Access phase decode
  assign wrAccess = psel && penable && pwrite;
  assign rdAccess = psel && penable && !pwrite;
  assign statusWr = wrAccess && (paddr == StatusAddr);
  assign statusRd = rdAccess && (paddr == StatusAddr);
  assign frameWr  = wrAccess && (paddr == FrameCtrlAddr);

  assign pready = 1'b1;  // No wait states

  //--------------------------------------
  // Channel register routing
  //--------------------------------------
  assign pulse1.wrEn    = wrAccess && (paddr[4:2] == Pulse1Base[4:2]);
  assign pulse1.regAddr = paddr[1:0];
  assign pulse1.wrData  = pwdata;
  assign pulse1.enabled = enableBits[0];

  assign pulse2.wrEn    = wrAccess && (paddr[4:2] == Pulse2Base[4:2]);
  assign pulse2.regAddr = paddr[1:0];
  assign pulse2.wrData  = pwdata;
  assign pulse2.enabled = enableBits[1];

  //--------------------------------------
  // Control and interrupt state
  //--------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      enableBits <= 2'b00;
      seqMode    <= 1'b0;
      irqInhibit <= 1'b0;
      frameIrq   <= 1'b0;
    end else begin
      if (statusWr)
        enableBits <= pwdata[1:0];
      if (frameWr) begin
        seqMode    <= pwdata[7];  // 1 selects the 5-step sequence
        irqInhibit <= pwdata[6];
      end
      // A new frame event wins over a clear in the same cycle
      if (frameEvent && !irqInhibit)
        frameIrq <= 1'b1;
      else if (statusRd || (frameWr && pwdata[6]))
        frameIrq <= 1'b0;
    end
  end

  assign restart = frameWr;  // Sequencer zeroes its counter on the write
  assign irq     = frameIrq;

  assign statusByte = {1'b0, frameIrq, 4'b0000, pulse2.lengthActive, pulse1.lengthActive};
  assign prdata     = (psel && !pwrite && paddr == StatusAddr) ? statusByte : 8'h00;

endmodule

/* rtl/apuTop.sv */
//--------------------------------------
// Pulse APU top level
//--------------------------------------
`timescale 1ns/1ps

module apuTop
  import apuPkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       psel,
  input  logic       penable,
  input  logic       pwrite,
  input  regAddrT    paddr,
  input  logic [7:0] pwdata,
  output logic [7:0] prdata,
  output logic       pready,
  output mixOutT     sample,
  output logic       irq
);

  logic   seqMode;
  logic   restart;
  logic   frameEvent;
  logic   quarterFrame;
  logic   halfFrame;
  sampleT pulse1Sample;
  sampleT pulse2Sample;

  pulseRegIf pulse1Regs ();
  pulseRegIf pulse2Regs ();

  apbRegBank regBank (
    .clk        (clk),
    .reset      (reset),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .frameEvent (frameEvent),
    .prdata     (prdata),
    .pready     (pready),
    .seqMode    (seqMode),
    .restart    (restart),
    .irq        (irq),
    .pulse1     (pulse1Regs.bank),
    .pulse2     (pulse2Regs.bank)
  );

  frameSequencer frameSeq (
    .clk          (clk),
    .reset        (reset),
    .seqMode      (seqMode),
    .restart      (restart),
    .quarterFrame (quarterFrame),
    .halfFrame    (halfFrame),
    .frameEvent   (frameEvent)
  );

  // Channel 2 uses two's complement sweep negation
  pulseChannel #(.negateCarry(1'b0)) pulse1 (
    .clk          (clk),
    .reset        (reset),
    .quarterFrame (quarterFrame),
    .halfFrame    (halfFrame),
    .regs         (pulse1Regs.channel),
    .sample       (pulse1Sample)
  );

  pulseChannel #(.negateCarry(1'b1)) pulse2 (
    .clk          (clk),
    .reset        (reset),
    .quarterFrame (quarterFrame),
    .halfFrame    (halfFrame),
    .regs         (pulse2Regs.channel),
    .sample       (pulse2Sample)
  );

  pulseMixer mixer (
    .clk          (clk),
    .reset        (reset),
    .pulse1Sample (pulse1Sample),
    .pulse2Sample (pulse2Sample),
    .sample       (sample)
  );

endmodule

/* rtl/frameSequencer.sv */
//--------------------------------------
// Frame sequencer
//--------------------------------------
`timescale 1ns/1ps

module frameSequencer
  import apuPkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic seqMode,
  input  logic restart,
  output logic quarterFrame,
  output logic halfFrame,
  output logic frameEvent
);

  logic [15:0] cycleCount;
  logic        quarterQ;
  logic        halfQ;
  logic        restartQ;  // Restart seen last cycle, mode is now settled

  // Mode 0 (4-step)         Mode 1 (5-step)
  //   q  q+h  q  q+h+irq      q  q+h  q  -  q+h
  always_ff @(posedge clk) begin
    if (reset) begin
      cycleCount <= 16'd0;
      quarterQ   <= 1'b0;
      halfQ      <= 1'b0;
      frameEvent <= 1'b0;
      restartQ   <= 1'b0;
    end else begin
      quarterQ   <= 1'b0;
      halfQ      <= 1'b0;
      frameEvent <= 1'b0;
      restartQ   <= restart;
      cycleCount <= cycleCount + 16'd1;

      case (cycleCount)
        StepQuarter1,
        StepQuarter3: begin
          quarterQ <= 1'b1;
        end
        StepHalf1: begin
          quarterQ <= 1'b1;
          halfQ    <= 1'b1;
        end
        StepEnd4: begin
          if (!seqMode) begin
            quarterQ   <= 1'b1;
            halfQ      <= 1'b1;
            frameEvent <= 1'b1;
            cycleCount <= 16'd0;  // 4-step wrap
          end
        end
        StepEnd5: begin
          if (seqMode) begin
            quarterQ   <= 1'b1;
            halfQ      <= 1'b1;
            cycleCount <= 16'd0;  // 5-step wrap
          end
        end
        default: begin
        end
      endcase

      if (restart)
        cycleCount <= 16'd0;
    end
  end

  // 5-step mode clocks the channels right after a restart
  assign quarterFrame = quarterQ | (restartQ & seqMode);
  assign halfFrame    = halfQ | (restartQ & seqMode);

endmodule

/* rtl/pulseMixer.sv */
//--------------------------------------
// Pulse mixer
//--------------------------------------
`timescale 1ns/1ps

module pulseMixer
  import apuPkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  sampleT pulse1Sample,
  input  sampleT pulse2Sample,
  output mixOutT sample
);

  logic [4:0] mixIndex;  // 0..30

  assign mixIndex = {1'b0, pulse1Sample} + {1'b0, pulse2Sample};

  always_ff @(posedge clk) begin
    if (reset)
      sample <= '0;
    else
      sample <= PulseMixTable[mixIndex];
  end

endmodule

/* sim.f */
common/apuPkg.sv
common/pulseRegIf.sv
rtl/apbRegBank.sv
rtl/frameSequencer.sv
pulse/pulseChannel.sv
rtl/pulseMixer.sv
rtl/apuTop.sv
verif/apu_properties.sv
verif/apuTb.sv

/* verif/apuTb.sv */
//--------------------------------------
// Pulse APU testbench
//--------------------------------------
`timescale 1ns/1ps

module apuTb
  import apuPkg::*;
();

  localparam int TimeoutCycles = 250000;  // About eight frame periods
  localparam int FrameLen      = int'(StepEnd4);

  logic       clk;
  logic       reset;
  logic       psel;
  logic       penable;
  logic       pwrite;
  regAddrT    paddr;
  logic [7:0] pwdata;
  logic [7:0] prdata;
  logic       pready;
  mixOutT     sample;
  logic       irq;

  int         errorCount  = 0;
  int         testCount   = 0;
  int         failedTests = 0;
  int         cycleCount  = 0;
  logic [7:0] lfsrState   = 8'd59;

  apuTop DUT (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .sample  (sample),
    .irq     (irq)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Run limit
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("=== FAIL ===");
      $finish;
    end
  end

  //--------------------------------------
  // Random volumes
  //--------------------------------------
  // Galois form of x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsrNext(input logic [7:0] s);
    return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
  endfunction

  function automatic sampleT randomVolume();
    sampleT v;
    v = '0;
    for (int i = 0; i < 4; i++) begin
      v         = {v[2:0], lfsrState[0]};  // One step per bit
      lfsrState = lfsrNext(lfsrState);
    end
    return v;
  endfunction

  //--------------------------------------
  // APB access
  //--------------------------------------
  task automatic apbWrite(input regAddrT addr, input logic [7:0] data);
    @(posedge clk);
    psel    <= 1'b1;  // Setup
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;  // Access
    @(negedge clk);
    checkReady(pready, 1'b1, "pready in write access cycle");
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apbRead(input regAddrT addr, output logic [7:0] data);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    data = prdata;  // Valid mid access cycle
    checkReady(pready, 1'b1, "pready in read access cycle");
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic writeChannel(input regAddrT base, input logic [7:0] reg0,
                              input logic [7:0] reg1, input logic [7:0] reg2,
                              input logic [7:0] reg3);
    apbWrite(base, reg0);
    apbWrite(base + 5'd1, reg1);
    apbWrite(base + 5'd2, reg2);
    apbWrite(base + 5'd3, reg3);
  endtask

  //--------------------------------------
  // Compare and report
  //--------------------------------------
  task automatic checkSample(input mixOutT got, input mixOutT exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s, sample %0d, expected %0d", $time, what, got, exp);
      errorCount++;
    end
  endtask

  task automatic checkStatus(input logic [7:0] got, input logic [7:0] exp,
                             input logic [7:0] mask, input string what);
    if ((got & mask) !== (exp & mask)) begin
      $display("[FAIL] %0t ns: %s, status 0x%02h, expected 0x%02h under mask 0x%02h",
               $time, what, got, exp, mask);
      errorCount++;
    end
  endtask

  task automatic checkIrq(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s, irq %b, expected %b", $time, what, got, exp);
      errorCount++;
    end
  endtask

  task automatic checkReady(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s, pready %b, expected %b", $time, what, got, exp);
      errorCount++;
    end
  endtask

  task automatic endTest(input string name, input int errBefore);
    testCount++;
    if (errorCount == errBefore) begin
      $display("Test %0d %s: ok", testCount, name);
    end else begin
      failedTests++;
      $display("Test %0d %s: %0d check(s) failed", testCount, name, errorCount - errBefore);
    end
  endtask

  //--------------------------------------
  // Tests
  //--------------------------------------
  task automatic constVolumeMix();
    int         errBefore;
    sampleT     v1;
    sampleT     v2;
    logic [4:0] sumIdx;
    logic       nonzeroSeen;
    errBefore   = errorCount;
    nonzeroSeen = 1'b0;
    v1 = randomVolume();
    v2 = randomVolume();
    if (v1 == 4'd0)
      v1 = 4'd1;  // Keep one channel audible
    sumIdx = {1'b0, v1} + {1'b0, v2};
    @(negedge clk);
    checkSample(sample, PulseMixTable[0], "sample after reset");
    checkIrq(irq, 1'b0, "irq after reset");
    apbWrite(StatusAddr, 8'h03);
    // 50% duty, length halted, constant volume, period 0x40
    writeChannel(Pulse1Base, {4'hB, v1}, 8'h00, 8'h40, 8'h08);
    writeChannel(Pulse2Base, {4'hB, v2}, 8'h00, 8'h40, 8'h08);
    for (int i = 0; i < 4000; i++) begin
      @(negedge clk);
      if (sample != '0)
        nonzeroSeen = 1'b1;
      if (sample !== PulseMixTable[0] && sample !== PulseMixTable[v1] &&
          sample !== PulseMixTable[v2] && sample !== PulseMixTable[sumIdx]) begin
        $display("[FAIL] %0t ns: sample %0d is not a mix of volumes %0d and %0d",
                 $time, sample, v1, v2);
        errorCount++;
        break;
      end
    end
    if (!nonzeroSeen) begin
      $display("No nonzero sample was seen in 4000 cycles of constant-volume output");
      errorCount++;
    end
    endTest("constant-volume mixing", errBefore);
  endtask

  task automatic statusDisable();
    int         errBefore;
    int         errLoop;
    logic [7:0] status;
    errBefore = errorCount;
    apbRead(StatusAddr, status);
    checkStatus(status, 8'h03, 8'h03, "status with both lengths loaded");
    apbWrite(StatusAddr, 8'h00);
    apbRead(StatusAddr, status);
    checkStatus(status, 8'h00, 8'h03, "status after disable");
    errLoop = errorCount;
    for (int i = 0; i < 200; i++) begin
      @(negedge clk);
      checkSample(sample, PulseMixTable[0], "sample with channels disabled");
      if (errorCount != errLoop)
        break;
    end
    endTest("status and disable", errBefore);
  endtask

  task automatic lengthExpiry();
    int         errBefore;
    logic [7:0] status;
    errBefore = errorCount;
    apbWrite(StatusAddr, 8'h01);
    apbWrite(FrameCtrlAddr, 8'h00);  // Mode 0, also restarts the sequence
    writeChannel(Pulse1Base, 8'h98, 8'h00, 8'h40, 8'h18);  // Halt clear, length index 3
    apbRead(StatusAddr, status);
    checkStatus(status, 8'h01, 8'h01, "channel 1 status after length load");
    repeat (2 * FrameLen + 10) @(posedge clk);
    apbRead(StatusAddr, status);
    checkStatus(status, 8'h00, 8'h01, "channel 1 status after two frames");
    endTest("length expiry", errBefore);
  endtask

  task automatic frameInterrupt();
    int         errBefore;
    int         waited;
    logic [7:0] status;
    errBefore = errorCount;
    apbWrite(FrameCtrlAddr, 8'h40);  // Clears any pending flag
    apbWrite(FrameCtrlAddr, 8'h00);  // Restart with interrupts allowed
    @(negedge clk);
    checkIrq(irq, 1'b0, "irq right after restart");
    waited = 0;  // Edges since the counter was zeroed
    while (irq !== 1'b1 && waited < FrameLen + 2) begin
      @(negedge clk);
      waited++;
    end
    checkIrq(irq, 1'b1, "irq at the end of a 4-step frame");
    apbRead(StatusAddr, status);
    checkStatus(status, 8'h40, 8'h40, "frame interrupt bit in status");
    @(negedge clk);
    checkIrq(irq, 1'b0, "irq after status read");
    apbWrite(FrameCtrlAddr, 8'h40);  // Inhibit
    for (int i = 0; i < FrameLen + 10; i++) begin
      @(negedge clk);
      if (irq !== 1'b0)
        break;
    end
    checkIrq(irq, 1'b0, "irq with inhibit set");
    endTest("frame interrupt", errBefore);
  endtask

  task automatic invalidPeriodMute();
    int         errBefore;
    int         errLoop;
    logic [7:0] status;
    errBefore = errorCount;
    apbWrite(StatusAddr, 8'h01);
    writeChannel(Pulse1Base, 8'hBF, 8'h00, 8'h05, 8'h08);  // Volume 15, period 5
    apbRead(StatusAddr, status);
    checkStatus(status, 8'h01, 8'h01, "channel 1 status with short period");
    errLoop = errorCount;
    for (int i = 0; i < 2000; i++) begin
      @(negedge clk);
      checkSample(sample, PulseMixTable[0], "sample with period below minimum");
      if (errorCount != errLoop)
        break;
    end
    endTest("invalid-period muting", errBefore);
  endtask

  initial begin
    reset   <= 1'b1;
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= '0;
    pwdata  <= 8'h00;
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    constVolumeMix();
    statusDisable();
    lengthExpiry();
    frameInterrupt();
    invalidPeriodMute();

    $display("Tests run: %0d, tests failed: %0d, failed checks: %0d",
             testCount, failedTests, errorCount);
    if (errorCount == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

/* verif/apu_properties.sv */
//--------------------------------------
// APB and frame strobe assertions
//--------------------------------------
`timescale 1ns/1ps

module apuProperties #(
  parameter bit watchApb = 1'b1  // 1 watches APB, 0 watches the frame strobes
) (
  input logic clk,
  input logic reset,
  input logic psel,
  input logic penable,
  input logic pready,
  input logic quarterFrame,
  input logic halfFrame
);

  if (watchApb) begin : apbProps
    readyHigh: assert property (@(posedge clk) disable iff (reset) pready)
      else $error("pready went low");

    // Access phase must follow a setup phase
    accessAfterSetup: assert property (@(posedge clk) disable iff (reset)
      penable |-> psel && $past(psel && !penable))
      else $error("penable without a preceding setup cycle");
  end else begin : strobeProps
    quarterPulse: assert property (@(posedge clk) disable iff (reset)
      quarterFrame |=> !quarterFrame)
      else $error("quarterFrame held for more than one cycle");

    halfPulse: assert property (@(posedge clk) disable iff (reset)
      halfFrame |=> !halfFrame)
      else $error("halfFrame held for more than one cycle");

    halfWithQuarter: assert property (@(posedge clk) disable iff (reset)
      halfFrame |-> quarterFrame)
      else $error("halfFrame without quarterFrame");
  end

endmodule

// Bank copy watches APB, sequencer copy watches the strobes
bind apbRegBank apuProperties #(.watchApb(1'b1)) apbChecks (
  .clk          (clk),
  .reset        (reset),
  .psel         (psel),
  .penable      (penable),
  .pready       (pready),
  .quarterFrame (1'b0),
  .halfFrame    (1'b0)
);

bind frameSequencer apuProperties #(.watchApb(1'b0)) strobeChecks (
  .clk          (clk),
  .reset        (reset),
  .psel         (1'b0),
  .penable      (1'b0),
  .pready       (1'b1),
  .quarterFrame (quarterFrame),
  .halfFrame    (halfFrame)
);
